// File: execPkg.sv
package execPkg;

  localparam int xlenDefault = 32;

  // operation class from the main decoder
  typedef enum logic [2:0] {
    clsMem    = 3'b000,
    clsBranch = 3'b001,
    clsReg    = 3'b010,
    clsUpper  = 3'b011,
    clsAtomic = 3'b100,
    clsImm    = 3'b110
  } opClassT;

  typedef enum logic [5:0] {
    aluAnd    = 6'b000000,
    aluOr     = 6'b000001,
    aluAdd    = 6'b000010,
    aluSll    = 6'b000011,
    aluSrl    = 6'b000100,
    aluXor    = 6'b000101,
    aluSub    = 6'b000110,
    aluSra    = 6'b000111,
    aluBeq    = 6'b001000,
    aluBne    = 6'b001001,
    aluBlt    = 6'b001010,
    aluBge    = 6'b001011,
    aluBltu   = 6'b001100,
    aluBgeu   = 6'b001101,
    aluMul    = 6'b010000,
    aluMulh   = 6'b010001,
    aluMulhsu = 6'b010010,
    aluMulhu  = 6'b010011,
    aluDiv    = 6'b010100,
    aluDivu   = 6'b010101,
    aluRem    = 6'b010110,
    aluRemu   = 6'b010111,
    aluMin    = 6'b100000,
    aluMax    = 6'b100001,
    aluMinu   = 6'b100010,
    aluMaxu   = 6'b100011,
    aluSwap   = 6'b100100,
    aluPassB  = 6'b111111
  } aluCodeT;

  // M extension codes all sit in 010xxx
  function automatic logic isMulDiv(aluCodeT code);
    return code[5:3] == 3'b010;
  endfunction

endpackage

// File: aluControl.sv
`timescale 1ns/1ps

module aluControl (
  input  execPkg::opClassT opClass,
  input  logic [2:0]       func3,
  input  logic [6:0]       func7,
  output execPkg::aluCodeT aluCode
);

  import execPkg::*;

  always_comb begin
    case (opClass)
      clsMem: aluCode = aluAdd;  // address generation
      clsBranch: begin
        case (func3)
          3'b000:  aluCode = aluBeq;
          3'b001:  aluCode = aluBne;
          3'b100:  aluCode = aluBlt;
          3'b101:  aluCode = aluBge;
          3'b110:  aluCode = aluBltu;
          3'b111:  aluCode = aluBgeu;
          default: aluCode = aluBeq;
        endcase
      end
      clsUpper: aluCode = aluPassB;  // lui and auipc
      clsAtomic: begin
        case (func7[6:2])
          5'b00010: aluCode = aluAdd;  // lr
          5'b00011: aluCode = aluAdd;  // sc
          5'b00000: aluCode = aluAdd;
          5'b00100: aluCode = aluXor;
          5'b01100: aluCode = aluAnd;
          5'b01000: aluCode = aluOr;
          5'b10000: aluCode = aluMin;
          5'b10100: aluCode = aluMax;
          5'b11000: aluCode = aluMinu;
          5'b11100: aluCode = aluMaxu;
          5'b00001: aluCode = aluSwap;
          default:  aluCode = aluAdd;
        endcase
      end
      clsReg: begin
        if (func7[0]) begin
          // M extension, func3 picks the exact operation
          case (func3)
            3'b000: aluCode = aluMul;
            3'b001: aluCode = aluMulh;
            3'b010: aluCode = aluMulhsu;
            3'b011: aluCode = aluMulhu;
            3'b100: aluCode = aluDiv;
            3'b101: aluCode = aluDivu;
            3'b110: aluCode = aluRem;
            default: aluCode = aluRemu;
          endcase
        end else begin
          case (func3)
            3'b000:  aluCode = func7[5] ? aluSub : aluAdd;
            3'b001:  aluCode = aluSll;
            3'b100:  aluCode = aluXor;
            3'b101:  aluCode = func7[5] ? aluSra : aluSrl;
            3'b110:  aluCode = aluOr;
            3'b111:  aluCode = aluAnd;
            default: aluCode = aluAdd;  // slt and sltu not decoded
          endcase
        end
      end
      clsImm: begin
        case (func3)
          3'b000:  aluCode = aluAdd;
          3'b001:  aluCode = aluSll;
          3'b100:  aluCode = aluXor;
          3'b101:  aluCode = func7[5] ? aluSra : aluSrl;  // srai or srli
          3'b110:  aluCode = aluOr;
          3'b111:  aluCode = aluAnd;
          default: aluCode = aluAdd;
        endcase
      end
      default: aluCode = aluAdd;
    endcase
  end

endmodule

// File: intAlu.sv
`timescale 1ns/1ps

module intAlu #(
  parameter int xlen = execPkg::xlenDefault
) (
  input  execPkg::aluCodeT aluCode,
  input  logic [xlen-1:0]  opA,
  input  logic [xlen-1:0]  opB,
  output logic [xlen-1:0]  aluResult
);

  import execPkg::*;

  localparam int shW = $clog2(xlen);

  logic [shW-1:0]  shamt;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] diff;
  logic            eq;
  logic            ltS;
  logic            ltU;
  logic            taken;

  assign shamt = opB[shW-1:0];  // low bits only
  assign sum   = opA + opB;
  assign diff  = opA - opB;
  assign eq    = (opA == opB);
  assign ltS   = $signed(opA) < $signed(opB);
  assign ltU   = opA < opB;

  // branch outcome for the six compare codes
  always_comb begin
    case (aluCode)
      aluBeq:  taken = eq;
      aluBne:  taken = !eq;
      aluBlt:  taken = ltS;
      aluBge:  taken = !ltS;
      aluBltu: taken = ltU;
      aluBgeu: taken = !ltU;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (aluCode)
      aluAnd: aluResult = opA & opB;
      aluOr:  aluResult = opA | opB;
      aluXor: aluResult = opA ^ opB;
      aluAdd: aluResult = sum;
      aluSub: aluResult = diff;
      aluSll: aluResult = opA << shamt;
      aluSrl: aluResult = opA >> shamt;
      aluSra: aluResult = $signed(opA) >>> shamt;

      aluBeq,
      aluBne,
      aluBlt,
      aluBge,
      aluBltu,
      aluBgeu: aluResult = {{(xlen-1){1'b0}}, taken};

      aluMin:  aluResult = ltS ? opA : opB;
      aluMax:  aluResult = ltS ? opB : opA;
      aluMinu: aluResult = ltU ? opA : opB;
      aluMaxu: aluResult = ltU ? opB : opA;

      aluSwap,
      aluPassB: aluResult = opB;

      default: aluResult = '0;  // M codes go to mulDivUnit
    endcase
  end

endmodule

// File: mulDivUnit.sv
`timescale 1ns/1ps

module mulDivUnit #(
  parameter int xlen = execPkg::xlenDefault
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  execPkg::aluCodeT mdCode,
  input  logic [xlen-1:0]  opA,
  input  logic [xlen-1:0]  opB,
  output logic             done,
  output logic [xlen-1:0]  mdResult
);

  import execPkg::*;

  localparam int cntW = $clog2(xlen);

  logic              busy;
  logic [cntW-1:0]   count;
  aluCodeT           codeR;
  logic [2*xlen-1:0] acc;      // product, or remainder and quotient
  logic [xlen-1:0]   operB;    // multiplicand or divisor magnitude
  logic              negRes;   // negate product or quotient
  logic              negRem;
  logic              divZero;

  logic              signedA;
  logic              signedB;
  logic              signA;
  logic              signB;
  logic [xlen-1:0]   magA;
  logic [xlen-1:0]   magB;

  logic [xlen:0]     addSum;
  logic [xlen:0]     remShift;
  logic              remGeq;
  logic [xlen:0]     remTrial;
  logic [2*xlen-1:0] accNext;

  logic [2*xlen-1:0] product;
  logic [xlen-1:0]   quotient;
  logic [xlen-1:0]   remainder;

  // operand signedness by code
  assign signedA = (mdCode == aluMulh) || (mdCode == aluMulhsu) ||
                   (mdCode == aluDiv) || (mdCode == aluRem);
  assign signedB = (mdCode == aluMulh) || (mdCode == aluDiv) || (mdCode == aluRem);
  assign signA   = signedA & opA[xlen-1];
  assign signB   = signedB & opB[xlen-1];
  assign magA    = signA ? -opA : opA;
  assign magB    = signB ? -opB : opB;

  // one shift-add step, carry kept in addSum
  assign addSum = acc[0] ? {1'b0, acc[2*xlen-1:xlen]} + {1'b0, operB}
                         : {1'b0, acc[2*xlen-1:xlen]};

  // one restoring divide step
  assign remShift = {acc[2*xlen-1:xlen], acc[xlen-1]};
  assign remGeq   = remShift >= {1'b0, operB};
  assign remTrial = remGeq ? remShift - {1'b0, operB} : remShift;

  assign accNext = codeR[2] ? {remTrial[xlen-1:0], acc[xlen-2:0], remGeq}
                            : {addSum, acc[xlen-1:1]};

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      count <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin  // restarts a run that was abandoned
        busy  <= 1'b1;
        count <= cntW'(xlen - 1);
      end else if (busy) begin
        if (count == '0) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      codeR   <= mdCode;
      acc     <= {{xlen{1'b0}}, magA};
      operB   <= magB;
      negRes  <= signA ^ signB;
      negRem  <= signA;
      divZero <= (opB == '0);
    end else if (busy) begin
      acc <= accNext;
    end
  end

  // most negative over minus one falls out as dividend and zero remainder
  assign product   = negRes ? -acc : acc;
  assign quotient  = divZero ? '1 : (negRes ? -acc[xlen-1:0] : acc[xlen-1:0]);
  assign remainder = negRem ? -acc[2*xlen-1:xlen] : acc[2*xlen-1:xlen];

  always_comb begin
    case (codeR)
      aluMul:                       mdResult = product[xlen-1:0];
      aluMulh, aluMulhsu, aluMulhu: mdResult = product[2*xlen-1:xlen];
      aluDiv, aluDivu:              mdResult = quotient;
      default:                      mdResult = remainder;  // rem and remu
    endcase
  end

endmodule

// File: execUnit.sv
`timescale 1ns/1ps

module execUnit #(
  parameter int xlen = execPkg::xlenDefault
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             cyc,
  input  logic             stb,
  input  execPkg::opClassT opClass,
  input  logic [2:0]       func3,
  input  logic [6:0]       func7,
  input  logic [xlen-1:0]  opA,
  input  logic [xlen-1:0]  opB,
  output logic             ack,
  output logic [xlen-1:0]  result
);

  import execPkg::*;

  typedef enum logic [1:0] {
    sIdle,
    sMulDiv,  // waiting on the iterative engine
    sAck
  } stateT;

  stateT           state;
  aluCodeT         aluCode;
  logic [xlen-1:0] aluResult;
  logic [xlen-1:0] mdResult;
  logic            start;
  logic            done;
  logic            req;
  logic            takeAlu;
  logic            takeMd;

  aluControl decode_i (
    .opClass (opClass),
    .func3   (func3),
    .func7   (func7),
    .aluCode (aluCode)
  );

  intAlu #(
    .xlen (xlen)
  ) alu_i (
    .aluCode   (aluCode),
    .opA       (opA),
    .opB       (opB),
    .aluResult (aluResult)
  );

  mulDivUnit #(
    .xlen (xlen)
  ) mulDiv_i (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .mdCode   (aluCode),
    .opA      (opA),
    .opB      (opB),
    .done     (done),
    .mdResult (mdResult)
  );

  assign req     = cyc & stb;
  assign takeAlu = (state == sIdle) && req && !isMulDiv(aluCode);
  // a done left over from an abandoned run can coincide with start
  assign takeMd  = (state == sMulDiv) && req && done && !start;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sIdle;
      ack   <= 1'b0;
      start <= 1'b0;
    end else begin
      ack   <= 1'b0;
      start <= 1'b0;
      case (state)
        sIdle: begin
          if (takeAlu) begin
            ack   <= 1'b1;
            state <= sAck;
          end else if (req) begin
            start <= 1'b1;  // M operation
            state <= sMulDiv;
          end
        end
        sMulDiv: begin
          if (!req) begin
            state <= sIdle;  // master gave up, no ack
          end else if (takeMd) begin
            ack   <= 1'b1;
            state <= sAck;
          end
        end
        sAck:    state <= sIdle;  // ack high this cycle
        default: state <= sIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (takeAlu) begin
      result <= aluResult;
    end else if (takeMd) begin
      result <= mdResult;
    end
  end

endmodule

// File: execTb.sv
`timescale 1ns/1ps

module execTb;

  import execPkg::*;

  localparam int xlen = 32;
  localparam int shW = $clog2(xlen);
  localparam logic [xlen-1:0] minNeg = {1'b1, {(xlen-1){1'b0}}};
  // sweeps plus overflow pair, abandoned divide (counted twice) and recovery
  localparam int numOps = 60 + 60 + 48 + 44 + 8 + 8 + 96 + 2 + 2 + 2;
  localparam int timeoutLimit = numOps * (xlen + 8) + 100;

  logic            clk;
  logic            reset;
  logic            cyc;
  logic            stb;
  opClassT         opClass;
  logic [2:0]      func3;
  logic [6:0]      func7;
  logic [xlen-1:0] opA;
  logic [xlen-1:0] opB;
  logic            ack;
  logic [xlen-1:0] result;

  integer          seed = 25114;
  int              cycles = 0;
  int              mismatches = 0;
  int              failures = 0;
  int              opCount = 0;
  int              ackCount = 0;
  logic [xlen-1:0] expQ[$];
  logic [xlen-1:0] expWord;

  logic [2:0] aluF3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  // amo funct5: lr, sc, add, xor, and, or, min, max, minu, maxu, swap
  logic [4:0] amoF5 [11] = '{5'b00010, 5'b00011, 5'b00000, 5'b00100, 5'b01100, 5'b01000,
                             5'b10000, 5'b10100, 5'b11000, 5'b11100, 5'b00001};

  execUnit #(.xlen(xlen)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeoutLimit) begin
      $display("Timeout: run did not finish within %0d cycles", timeoutLimit);
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
      $display("Some tests failed");
      $finish;
    end
  end

  // compares every ack against the oldest expected word
  always @(posedge clk) begin
    if (reset) begin
      if (cycles > 0 && ack !== 1'b0) begin  // first edge has not seen reset yet
        failures++;
        $display("ack was not low during reset");
      end
    end else if (ack) begin
      ackCount = ackCount + 1;
      if (expQ.size() == 0) begin
        failures++;
        $display("ack arrived with no operation pending");
      end else begin
        expWord = expQ.pop_front();
        checkResult(expWord, result);
      end
    end
  end

  task automatic checkResult(logic [xlen-1:0] expected, logic [xlen-1:0] actual);
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch result: expected %h actual %h", expected, actual);
    end
  endtask

  task automatic checkCount(string name, int expected, int actual);
    if (actual != expected) begin
      mismatches++;
      $display("Mismatch %s: expected %h actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [xlen-1:0] refExec(opClassT cls, logic [2:0] f3, logic [6:0] f7,
                                              logic [xlen-1:0] a, logic [xlen-1:0] b);
    logic [shW-1:0]         s;
    logic                   ltS;
    logic                   ltU;
    logic                   ovf;
    logic [2*xlen-1:0]      ea;
    logic [2*xlen-1:0]      eb;
    logic [2*xlen-1:0]      prod;
    logic signed [xlen-1:0] sq;
    logic signed [xlen-1:0] sr;
    s   = b[shW-1:0];
    ltS = $signed(a) < $signed(b);
    ltU = a < b;
    ovf = (a == minNeg) && (b == '1);
    ea  = (f3 == 3'b001 || f3 == 3'b010) ? {{xlen{a[xlen-1]}}, a} : {{xlen{1'b0}}, a};
    eb  = (f3 == 3'b001) ? {{xlen{b[xlen-1]}}, b} : {{xlen{1'b0}}, b};
    prod = ea * eb;  // exact low half for any signedness
    sq  = '0;
    sr  = '0;
    if (b != '0 && !ovf) begin
      sq = $signed(a) / $signed(b);  // signed quotient and remainder
      sr = $signed(a) % $signed(b);
    end
    case (cls)
      clsBranch: begin
        case (f3)
          3'b001:  return {{(xlen-1){1'b0}}, a != b};
          3'b100:  return {{(xlen-1){1'b0}}, ltS};
          3'b101:  return {{(xlen-1){1'b0}}, !ltS};
          3'b110:  return {{(xlen-1){1'b0}}, ltU};
          3'b111:  return {{(xlen-1){1'b0}}, !ltU};
          default: return {{(xlen-1){1'b0}}, a == b};
        endcase
      end
      clsUpper: return b;
      clsAtomic: begin
        case (f7[6:2])
          5'b00100: return a ^ b;
          5'b01100: return a & b;
          5'b01000: return a | b;
          5'b10000: return ltS ? a : b;
          5'b10100: return ltS ? b : a;
          5'b11000: return ltU ? a : b;
          5'b11100: return ltU ? b : a;
          5'b00001: return b;  // swap
          default:  return a + b;  // amoadd, lr, sc
        endcase
      end
      clsReg, clsImm: begin
        if (cls == clsReg && f7[0]) begin
          case (f3)
            3'b000:  return prod[xlen-1:0];
            3'b100:  return (b == '0) ? '1 : (ovf ? a : sq);
            3'b101:  return (b == '0) ? '1 : a / b;
            3'b110:  return (b == '0) ? a : (ovf ? '0 : sr);
            3'b111:  return (b == '0) ? a : a % b;
            default: return prod[2*xlen-1:xlen];  // high product variants
          endcase
        end
        case (f3)
          3'b000:  return (cls == clsReg && f7[5]) ? a - b : a + b;
          3'b001:  return a << s;
          3'b100:  return a ^ b;
          3'b101: begin
            if (f7[5]) return $signed(a) >>> s;
            return a >> s;
          end
          3'b110:  return a | b;
          3'b111:  return a & b;
          default: return a + b;
        endcase
      end
      default: return a + b;  // memory address
    endcase
  endfunction

  function automatic logic [xlen-1:0] operand(int i);
    case (i % 8)
      0:       return '0;
      1:       return 1;
      2:       return '1;
      3:       return minNeg;
      4:       return ~minNeg;
      default: return $random(seed);
    endcase
  endfunction

  task automatic runOp(opClassT cls, logic [2:0] f3, logic [6:0] f7,
                       logic [xlen-1:0] a, logic [xlen-1:0] b);
    expQ.push_back(refExec(cls, f3, f7, a, b));
    @(posedge clk);
    cyc     <= 1'b1;
    stb     <= 1'b1;
    opClass <= cls;
    func3   <= f3;
    func7   <= f7;
    opA     <= a;
    opB     <= b;
    do @(posedge clk); while (!ack);
    cyc <= 1'b0;
    stb <= 1'b0;
    opCount++;
  endtask

  task automatic randomOps(opClassT cls, int n);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [6:0]      f7;
    for (int i = 0; i < n; i++) begin
      a  = operand(i);
      b  = (i % 5 == 0) ? a : operand(i + 3);  // equal pairs now and then
      f7 = (cls == clsAtomic) ? {amoF5[i % 11], 2'b00} : {1'b0, i[3], 5'b00000};
      runOp(cls, aluF3[i % 6], f7, a, b);
    end
  endtask

  task automatic mulDivOps(int n);
    for (int i = 0; i < n; i++) begin
      runOp(clsReg, i[2:0], 7'b0000001, operand(i + i / 8), operand(i / 8));  // zero divisor too
    end
    runOp(clsReg, 3'b100, 7'b0000001, minNeg, '1);
    runOp(clsReg, 3'b110, 7'b0000001, minNeg, '1);
  endtask

  task automatic abandonDivide(logic [xlen-1:0] a, logic [xlen-1:0] b);
    @(posedge clk);
    cyc     <= 1'b1;
    stb     <= 1'b1;
    opClass <= clsReg;
    func3   <= 3'b100;
    func7   <= 7'b0000001;
    opA     <= a;
    opB     <= b;
    repeat (10) @(posedge clk);  // engine is mid-run here
    cyc <= 1'b0;
    stb <= 1'b0;
    repeat (xlen + 10) @(posedge clk);  // a stray ack would hit an empty queue
  endtask

  initial begin
    reset   = 1'b1;
    cyc     = 1'b0;
    stb     = 1'b0;
    opClass = clsMem;
    func3   = 3'b000;
    func7   = 7'b0000000;
    opA     = '0;
    opB     = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    randomOps(clsReg, 60);
    randomOps(clsImm, 60);
    randomOps(clsBranch, 48);
    randomOps(clsAtomic, 44);
    randomOps(clsMem, 8);
    randomOps(clsUpper, 8);
    mulDivOps(96);
    abandonDivide(32'h8765_4321, 32'h0000_0123);
    runOp(clsReg, 3'b100, 7'b0000001, 32'h8765_4321, 32'h0000_0123);
    runOp(clsReg, 3'b000, 7'b0000000, 32'h0000_1000, 32'h0000_0234);
    repeat (4) @(posedge clk);
    checkCount("ack count", opCount, ackCount);
    if (expQ.size() != 0) begin
      failures++;
      $display("%0d operations never received an ack", expQ.size());
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: compile.f
execPkg.sv
aluControl.sv
intAlu.sv
mulDivUnit.sv
execUnit.sv
execTb.sv

// File: Makefile
SRCS = execPkg.sv aluControl.sv intAlu.sv mulDivUnit.sv execUnit.sv execTb.sv

obj_dir/VexecTb: $(SRCS) compile.f
	verilator --binary --timing -Wno-fatal --top-module execTb -f compile.f

run: obj_dir/VexecTb
	./obj_dir/VexecTb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
